//--- include/noc_link_defines.svh
`ifndef NOC_LINK_DEFINES_SVH
`define NOC_LINK_DEFINES_SVH

// Link flit payload width in bits.
`define NOC_FLIT_WIDTH 16

// Request packet width, which is three flits on the link.
`define NOC_FWD_WIDTH 48

// Return packet width, which is two flits on the link.
`define NOC_REV_WIDTH 32

// Receive buffer depth per channel, also the credit count at reset.
`define NOC_CREDITS 4

// Credit counters must hold the full value, so one bit more than the log.
`define NOC_CREDIT_WIDTH $clog2(`NOC_CREDITS + 1)

// Address bits of one receive FIFO.
`define NOC_FIFO_ADDR_WIDTH $clog2(`NOC_CREDITS)

`endif

//--- src/noc_link_pkg.sv
`include "noc_link_defines.svh"

package noc_link_pkg;

  // Channel tag carried by every flit on the link.
  typedef enum logic
  {
    CHAN_FWD = 1'b0,
    CHAN_REV = 1'b1
  } noc_chan_e;

  typedef enum logic
  {
    SER_IDLE = 1'b0,
    SER_SEND = 1'b1
  } ser_state_e;

  // One link beat, the tag sits in the top bits.
  typedef struct packed
  {
    noc_chan_e                 chan;
    logic                      last;
    logic [`NOC_FLIT_WIDTH-1:0] data;
  } noc_flit_s;

endpackage

//--- src/wide_link_serializer.sv
`timescale 1ns/1ps

`include "noc_link_defines.svh"

module wide_link_serializer
 #(parameter int width_p = `NOC_FWD_WIDTH
  )
  (input                             core_clk_i
  ,input                             rst_i

  ,input                             v_i
  ,input  [width_p-1:0]              data_i
  ,output                            ready_and_o

  ,input  noc_link_pkg::noc_chan_e   chan_i

  ,output                            flit_v_o
  ,output noc_link_pkg::noc_flit_s   flit_o
  ,input                             yumi_i
  );

  import noc_link_pkg::*;

  localparam int flit_w_lp = `NOC_FLIT_WIDTH;
  localparam int els_lp    = (width_p + flit_w_lp - 1) / flit_w_lp;
  localparam int idx_w_lp  = (els_lp > 1) ? $clog2(els_lp) : 1;
  localparam int buf_w_lp  = els_lp * flit_w_lp;

  ser_state_e           state_r;
  logic [idx_w_lp-1:0]  idx_r;
  logic [buf_w_lp-1:0]  data_r;
  logic                 last_flit;

  assign last_flit = (idx_r == idx_w_lp'(els_lp - 1));

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      state_r <= SER_IDLE;
      idx_r   <= '0;
    end
    else
    begin
      case (state_r)
        SER_IDLE:
        begin
          if (v_i)
          begin
            state_r <= SER_SEND;
            idx_r   <= '0;
          end
        end
        SER_SEND:
        begin
          if (yumi_i)
          begin
            if (last_flit)
              state_r <= SER_IDLE; // Packet done, accept the next one.
            else
              idx_r <= idx_r + 1'b1;
          end
        end
        default: state_r <= SER_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if ((state_r == SER_IDLE) && v_i)
      data_r <= buf_w_lp'(data_i); // Low flit goes out first.
  end

  assign ready_and_o = (state_r == SER_IDLE);
  assign flit_v_o    = (state_r == SER_SEND);

  assign flit_o.chan = chan_i;
  assign flit_o.last = last_flit;
  assign flit_o.data = data_r[idx_r*flit_w_lp +: flit_w_lp];

endmodule

//--- src/channel_tunnel_tx.sv
`timescale 1ns/1ps

`include "noc_link_defines.svh"

module channel_tunnel_tx
  (input                             core_clk_i
  ,input                             rst_i

  ,input                             fwd_v_i
  ,input  noc_link_pkg::noc_flit_s   fwd_flit_i
  ,output                            fwd_yumi_o

  ,input                             rev_v_i
  ,input  noc_link_pkg::noc_flit_s   rev_flit_i
  ,output                            rev_yumi_o

  ,output                            link_v_o
  ,output noc_link_pkg::noc_flit_s   link_flit_o
  ,input  [1:0]                      link_token_i
  );

  import noc_link_pkg::*;

  localparam int cnt_w_lp = `NOC_CREDIT_WIDTH;

  logic [1:0][cnt_w_lp-1:0] credit_r;
  noc_chan_e                last_r;
  logic                     fwd_elig, rev_elig;
  logic                     grant_fwd, grant_rev;
  logic [1:0]               send;
  logic                     link_v_r;
  noc_flit_s                link_flit_r;

  assign fwd_elig = fwd_v_i & (credit_r[CHAN_FWD] != '0);
  assign rev_elig = rev_v_i & (credit_r[CHAN_REV] != '0);

  // On a tie the channel that did not go last wins.
  assign grant_rev = rev_elig & (~fwd_elig | (last_r == CHAN_FWD));
  assign grant_fwd = fwd_elig & ~grant_rev;

  assign send[CHAN_FWD] = grant_fwd;
  assign send[CHAN_REV] = grant_rev;

  assign fwd_yumi_o = grant_fwd;
  assign rev_yumi_o = grant_rev;

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < 2; i++)
        credit_r[i] <= cnt_w_lp'(`NOC_CREDITS);
      last_r   <= CHAN_REV; // Forward gets the first tie.
      link_v_r <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < 2; i++)
        credit_r[i] <= credit_r[i] - cnt_w_lp'(send[i]) + cnt_w_lp'(link_token_i[i]);
      if (grant_fwd | grant_rev)
        last_r <= grant_rev ? CHAN_REV : CHAN_FWD;
      link_v_r <= grant_fwd | grant_rev;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (grant_fwd | grant_rev)
      link_flit_r <= grant_rev ? rev_flit_i : fwd_flit_i;
  end

  assign link_v_o    = link_v_r;
  assign link_flit_o = link_flit_r;

endmodule

//--- src/channel_tunnel_rx.sv
`timescale 1ns/1ps

`include "noc_link_defines.svh"

module channel_tunnel_rx
  (input                             core_clk_i
  ,input                             rst_i

  ,input                             link_v_i
  ,input  noc_link_pkg::noc_flit_s   link_flit_i

  ,output                            fwd_v_o
  ,output noc_link_pkg::noc_flit_s   fwd_flit_o
  ,input                             fwd_yumi_i

  ,output                            rev_v_o
  ,output noc_link_pkg::noc_flit_s   rev_flit_o
  ,input                             rev_yumi_i
  );

  import noc_link_pkg::*;

  localparam int aw_lp = `NOC_FIFO_ADDR_WIDTH;

  // Pointers carry one wrap bit to tell full from empty.
  logic [1:0][aw_lp:0] wptr_r, rptr_r;
  noc_flit_s           mem_r [2][`NOC_CREDITS];
  logic [1:0]          wr_en, rd_en, not_empty;

  assign wr_en[CHAN_FWD] = link_v_i & (link_flit_i.chan == CHAN_FWD);
  assign wr_en[CHAN_REV] = link_v_i & (link_flit_i.chan == CHAN_REV);

  assign rd_en[CHAN_FWD] = fwd_yumi_i;
  assign rd_en[CHAN_REV] = rev_yumi_i;

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
    end
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        if (wr_en[i])
          wptr_r[i] <= wptr_r[i] + 1'b1;
        if (rd_en[i])
          rptr_r[i] <= rptr_r[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    for (int i = 0; i < 2; i++)
      if (wr_en[i])
        mem_r[i][wptr_r[i][aw_lp-1:0]] <= link_flit_i; // Space is guaranteed by credits.
  end

  for (genvar i = 0; i < 2; i++)
  begin: status
    assign not_empty[i] = (wptr_r[i] != rptr_r[i]);
  end

  assign fwd_v_o    = not_empty[CHAN_FWD];
  assign fwd_flit_o = mem_r[CHAN_FWD][rptr_r[CHAN_FWD][aw_lp-1:0]];
  assign rev_v_o    = not_empty[CHAN_REV];
  assign rev_flit_o = mem_r[CHAN_REV][rptr_r[CHAN_REV][aw_lp-1:0]];

endmodule

//--- src/wide_link_deserializer.sv
`timescale 1ns/1ps

`include "noc_link_defines.svh"

module wide_link_deserializer
 #(parameter int width_p = `NOC_FWD_WIDTH
  )
  (input                             core_clk_i
  ,input                             rst_i

  ,input                             flit_v_i
  ,input  noc_link_pkg::noc_flit_s   flit_i
  ,output                            yumi_o
  ,output                            token_o

  ,output                            v_o
  ,output [width_p-1:0]              data_o
  ,input                             ready_and_i
  );

  import noc_link_pkg::*;

  localparam int flit_w_lp = `NOC_FLIT_WIDTH;
  localparam int els_lp    = (width_p + flit_w_lp - 1) / flit_w_lp;
  localparam int idx_w_lp  = (els_lp > 1) ? $clog2(els_lp) : 1;

  logic [els_lp*flit_w_lp-1:0] data_r;
  logic [idx_w_lp-1:0]         idx_r;
  logic                        v_r;
  logic                        pop;

  // A held packet blocks further pops.
  assign pop = flit_v_i & ~v_r;

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      idx_r <= '0;
      v_r   <= 1'b0;
    end
    else if (pop)
    begin
      idx_r <= flit_i.last ? '0 : idx_r + 1'b1;
      v_r   <= flit_i.last;
    end
    else if (v_r & ready_and_i)
      v_r <= 1'b0;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (pop)
      data_r[idx_r*flit_w_lp +: flit_w_lp] <= flit_i.data;
  end

  assign yumi_o  = pop;
  assign token_o = pop; // One credit back per flit that leaves the FIFO.
  assign v_o     = v_r;
  assign data_o  = data_r[width_p-1:0];

endmodule

//--- src/noc_io_link.sv
`timescale 1ns/1ps

`include "noc_link_defines.svh"

module noc_io_link
  (input                              core_clk_i
  ,input                              rst_i

  ,input                              fwd_v_i
  ,input  [`NOC_FWD_WIDTH-1:0]        fwd_data_i
  ,output                             fwd_ready_and_o

  ,input                              rev_v_i
  ,input  [`NOC_REV_WIDTH-1:0]        rev_data_i
  ,output                             rev_ready_and_o

  ,output                             fwd_v_o
  ,output [`NOC_FWD_WIDTH-1:0]        fwd_data_o
  ,input                              fwd_ready_and_i

  ,output                             rev_v_o
  ,output [`NOC_REV_WIDTH-1:0]        rev_data_o
  ,input                              rev_ready_and_i

  ,output                             link_v_o
  ,output noc_link_pkg::noc_flit_s    link_flit_o
  ,input  [1:0]                       link_token_i

  ,input                              link_v_i
  ,input  noc_link_pkg::noc_flit_s    link_flit_i
  ,output [1:0]                       link_token_o
  );

  import noc_link_pkg::*;

  logic      fwd_ser_v, fwd_ser_yumi, rev_ser_v, rev_ser_yumi;
  noc_flit_s fwd_ser_flit, rev_ser_flit;
  logic      fwd_fifo_v, fwd_fifo_yumi, rev_fifo_v, rev_fifo_yumi;
  noc_flit_s fwd_fifo_flit, rev_fifo_flit;

  wide_link_serializer
 #(.width_p    (`NOC_FWD_WIDTH)
  ) u_fwd_ser
  (.core_clk_i (core_clk_i)
  ,.rst_i      (rst_i)
  ,.v_i        (fwd_v_i)
  ,.data_i     (fwd_data_i)
  ,.ready_and_o(fwd_ready_and_o)
  ,.chan_i     (CHAN_FWD)
  ,.flit_v_o   (fwd_ser_v)
  ,.flit_o     (fwd_ser_flit)
  ,.yumi_i     (fwd_ser_yumi)
  );

  wide_link_serializer
 #(.width_p    (`NOC_REV_WIDTH)
  ) u_rev_ser
  (.core_clk_i (core_clk_i)
  ,.rst_i      (rst_i)
  ,.v_i        (rev_v_i)
  ,.data_i     (rev_data_i)
  ,.ready_and_o(rev_ready_and_o)
  ,.chan_i     (CHAN_REV)
  ,.flit_v_o   (rev_ser_v)
  ,.flit_o     (rev_ser_flit)
  ,.yumi_i     (rev_ser_yumi)
  );

  channel_tunnel_tx u_tunnel_tx
  (.core_clk_i  (core_clk_i)
  ,.rst_i       (rst_i)
  ,.fwd_v_i     (fwd_ser_v)
  ,.fwd_flit_i  (fwd_ser_flit)
  ,.fwd_yumi_o  (fwd_ser_yumi)
  ,.rev_v_i     (rev_ser_v)
  ,.rev_flit_i  (rev_ser_flit)
  ,.rev_yumi_o  (rev_ser_yumi)
  ,.link_v_o    (link_v_o)
  ,.link_flit_o (link_flit_o)
  ,.link_token_i(link_token_i)
  );

  channel_tunnel_rx u_tunnel_rx
  (.core_clk_i (core_clk_i)
  ,.rst_i      (rst_i)
  ,.link_v_i   (link_v_i)
  ,.link_flit_i(link_flit_i)
  ,.fwd_v_o    (fwd_fifo_v)
  ,.fwd_flit_o (fwd_fifo_flit)
  ,.fwd_yumi_i (fwd_fifo_yumi)
  ,.rev_v_o    (rev_fifo_v)
  ,.rev_flit_o (rev_fifo_flit)
  ,.rev_yumi_i (rev_fifo_yumi)
  );

  wide_link_deserializer
 #(.width_p    (`NOC_FWD_WIDTH)
  ) u_fwd_deser
  (.core_clk_i (core_clk_i)
  ,.rst_i      (rst_i)
  ,.flit_v_i   (fwd_fifo_v)
  ,.flit_i     (fwd_fifo_flit)
  ,.yumi_o     (fwd_fifo_yumi)
  ,.token_o    (link_token_o[CHAN_FWD])
  ,.v_o        (fwd_v_o)
  ,.data_o     (fwd_data_o)
  ,.ready_and_i(fwd_ready_and_i)
  );

  wide_link_deserializer
 #(.width_p    (`NOC_REV_WIDTH)
  ) u_rev_deser
  (.core_clk_i (core_clk_i)
  ,.rst_i      (rst_i)
  ,.flit_v_i   (rev_fifo_v)
  ,.flit_i     (rev_fifo_flit)
  ,.yumi_o     (rev_fifo_yumi)
  ,.token_o    (link_token_o[CHAN_REV])
  ,.v_o        (rev_v_o)
  ,.data_o     (rev_data_o)
  ,.ready_and_i(rev_ready_and_i)
  );

endmodule

//--- bench/noc_io_link_checker.sv
`timescale 1ns/1ps

`include "noc_link_defines.svh"

module noc_io_link_checker
  (input                                core_clk_i
  ,input                                rst_i
  ,input                                link_v_i
  ,input  noc_link_pkg::noc_flit_s      link_flit_i
  ,input  [1:0][`NOC_CREDIT_WIDTH-1:0]  credit_i
  );

  import noc_link_pkg::*;

  localparam int                 cnt_w_lp      = `NOC_CREDIT_WIDTH;
  localparam logic [cnt_w_lp-1:0] max_credit_lp = cnt_w_lp'(`NOC_CREDITS);

  credit_bound: assert property (@(posedge core_clk_i) disable iff (rst_i)
    (credit_i[CHAN_FWD] <= max_credit_lp) && (credit_i[CHAN_REV] <= max_credit_lp))
    else $error("credit counter above the receive buffer depth");

  // A flit on the link was granted one cycle earlier, so its credit is checked there.
  fwd_send_credit: assert property (@(posedge core_clk_i) disable iff (rst_i)
    (link_v_i && (link_flit_i.chan == CHAN_FWD)) |-> ($past(credit_i[CHAN_FWD]) != '0))
    else $error("forward flit sent with no credit");

  rev_send_credit: assert property (@(posedge core_clk_i) disable iff (rst_i)
    (link_v_i && (link_flit_i.chan == CHAN_REV)) |-> ($past(credit_i[CHAN_REV]) != '0))
    else $error("return flit sent with no credit");

endmodule

bind channel_tunnel_tx noc_io_link_checker u_checker
  (.core_clk_i  (core_clk_i)
  ,.rst_i       (rst_i)
  ,.link_v_i    (link_v_o)
  ,.link_flit_i (link_flit_o)
  ,.credit_i    (credit_r)
  );

//--- bench/noc_io_link_tb.sv
`timescale 1ns/1ps

`include "noc_link_defines.svh"

module noc_io_link_tb;

  import noc_link_pkg::*;

  localparam int fwd_w_lp    = `NOC_FWD_WIDTH;
  localparam int rev_w_lp    = `NOC_REV_WIDTH;
  localparam int limit_lp    = 3000;
  localparam int held_max_lp = `NOC_CREDITS + 3; // Buffer plus the packet held at the output.

  logic                core_clk;
  logic                rst;
  logic                fwd_in_v, rev_in_v;
  logic [fwd_w_lp-1:0] fwd_in_data;
  logic [rev_w_lp-1:0] rev_in_data;
  logic                fwd_in_ready, rev_in_ready;
  logic                fwd_out_v, rev_out_v;
  logic [fwd_w_lp-1:0] fwd_out_data;
  logic [rev_w_lp-1:0] rev_out_data;
  logic                fwd_out_ready, rev_out_ready;
  logic                link_v;
  noc_flit_s           link_flit;
  logic [1:0]          link_token;

  logic [31:0]         lfsr_r;
  logic [63:0]         rnd;
  logic [fwd_w_lp-1:0] fwd_q [$];
  logic [rev_w_lp-1:0] rev_q [$];
  int                  fwd_left, rev_left;
  int                  fwd_link_cnt;
  logic                hold_fwd;
  string               test_name;

  // The link output is looped straight back into the receive side.
  noc_io_link u_noc_io_link
  (.core_clk_i     (core_clk)
  ,.rst_i          (rst)
  ,.fwd_v_i        (fwd_in_v)
  ,.fwd_data_i     (fwd_in_data)
  ,.fwd_ready_and_o(fwd_in_ready)
  ,.rev_v_i        (rev_in_v)
  ,.rev_data_i     (rev_in_data)
  ,.rev_ready_and_o(rev_in_ready)
  ,.fwd_v_o        (fwd_out_v)
  ,.fwd_data_o     (fwd_out_data)
  ,.fwd_ready_and_i(fwd_out_ready)
  ,.rev_v_o        (rev_out_v)
  ,.rev_data_o     (rev_out_data)
  ,.rev_ready_and_i(rev_out_ready)
  ,.link_v_o       (link_v)
  ,.link_flit_o    (link_flit)
  ,.link_token_i   (link_token)
  ,.link_v_i       (link_v)
  ,.link_flit_i    (link_flit)
  ,.link_token_o   (link_token)
  );

  initial core_clk = 1'b0;
  always #20 core_clk = ~core_clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
  endfunction

  task automatic take_bits(input int n);
    rnd = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_r = lfsr_next(lfsr_r);
      rnd    = {rnd[62:0], lfsr_r[0]};
    end
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected == actual)
    else
      fail_run($sformatf("mismatch %s %s expected %0h actual %0h",
                         test_name, what, expected, actual));
  endtask

  // One clock: sample what happened in the last cycle, then drive the next one.
  task automatic step_cycle();
    @(posedge core_clk);
    if (link_v && (link_flit.chan == CHAN_FWD))
      fwd_link_cnt++;
    if (hold_fwd)
    begin
      assert (fwd_link_cnt <= held_max_lp)
      else
        fail_run("more forward flits crossed the link than the receive side can hold");
    end
    if (fwd_out_v && fwd_out_ready)
    begin
      assert (fwd_q.size() != 0)
      else
        fail_run("forward packet delivered with none outstanding");
      check_value("fwd_data", 64'(fwd_q.pop_front()), 64'(fwd_out_data));
    end
    if (rev_out_v && rev_out_ready)
    begin
      assert (rev_q.size() != 0)
      else
        fail_run("return packet delivered with none outstanding");
      check_value("rev_data", 64'(rev_q.pop_front()), 64'(rev_out_data));
    end
    if (fwd_in_v && fwd_in_ready)
    begin
      fwd_q.push_back(fwd_in_data);
      fwd_left--;
    end
    if (!fwd_in_v || fwd_in_ready)
    begin
      take_bits(1);
      if ((fwd_left > 0) && rnd[0])
      begin
        take_bits(fwd_w_lp);
        fwd_in_v    <= 1'b1;
        fwd_in_data <= rnd[fwd_w_lp-1:0];
      end
      else
        fwd_in_v <= 1'b0;
    end
    if (rev_in_v && rev_in_ready)
    begin
      rev_q.push_back(rev_in_data);
      rev_left--;
    end
    if (!rev_in_v || rev_in_ready)
    begin
      take_bits(1);
      if ((rev_left > 0) && rnd[0])
      begin
        take_bits(rev_w_lp);
        rev_in_v    <= 1'b1;
        rev_in_data <= rnd[rev_w_lp-1:0];
      end
      else
        rev_in_v <= 1'b0;
    end
    take_bits(2);
    fwd_out_ready <= ~hold_fwd & (rnd[1:0] != 2'b00);
    take_bits(2);
    rev_out_ready <= (rnd[1:0] != 2'b00);
  endtask

  task automatic wait_drained(input logic rev_only);
    int cycles;
    cycles = 0;
    while ((rev_left != 0) || (rev_q.size() != 0)
           || (!rev_only && ((fwd_left != 0) || (fwd_q.size() != 0))))
    begin
      step_cycle();
      cycles++;
      if (cycles > limit_lp)
        fail_run($sformatf("timeout in %s while waiting for packets to arrive", test_name));
    end
  endtask

  task automatic wait_link_count(input int target);
    int cycles;
    cycles = 0;
    while (fwd_link_cnt < target)
    begin
      step_cycle();
      cycles++;
      if (cycles > limit_lp)
        fail_run($sformatf("timeout in %s while waiting for forward link flits", test_name));
    end
  endtask

  initial
  begin
    lfsr_r        = 32'hefaeb800;
    rst           = 1'b1;
    fwd_in_v      = 1'b0;
    fwd_in_data   = '0;
    rev_in_v      = 1'b0;
    rev_in_data   = '0;
    fwd_out_ready = 1'b0;
    rev_out_ready = 1'b0;
    fwd_left      = 0;
    rev_left      = 0;
    fwd_link_cnt  = 0;
    hold_fwd      = 1'b0;
    test_name     = "reset";
    repeat (4) @(posedge core_clk);
    rst <= 1'b0;
    @(posedge core_clk);
    check_value("link_v", 64'(0), 64'(link_v));
    check_value("link_token", 64'(0), 64'(link_token));
    check_value("fwd_out_v", 64'(0), 64'(fwd_out_v));
    check_value("rev_out_v", 64'(0), 64'(rev_out_v));
    check_value("fwd_in_ready", 64'(1), 64'(fwd_in_ready));
    check_value("rev_in_ready", 64'(1), 64'(rev_in_ready));

    test_name = "fwd_only";
    fwd_left  = 8;
    wait_drained(1'b0);

    test_name = "rev_only";
    rev_left  = 8;
    wait_drained(1'b0);

    test_name = "both_channels";
    fwd_left  = 12;
    rev_left  = 12;
    wait_drained(1'b0);

    // Forward output stalls, so forward credits run out while returns keep flowing.
    test_name     = "fwd_held";
    hold_fwd      = 1'b1;
    fwd_out_ready <= 1'b0;
    fwd_link_cnt  = 0;
    fwd_left      = 6;
    wait_link_count(held_max_lp);
    rev_left = 6;
    wait_drained(1'b1);
    check_value("fwd_in_ready_held", 64'(0), 64'(fwd_in_ready));
    hold_fwd = 1'b0;
    wait_drained(1'b0);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- list.f
+incdir+include
src/noc_link_pkg.sv
src/wide_link_serializer.sv
src/channel_tunnel_tx.sv
src/channel_tunnel_rx.sv
src/wide_link_deserializer.sv
src/noc_io_link.sv
bench/noc_io_link_checker.sv
bench/noc_io_link_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := noc_io_link_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
